// ==== src/bpu_defs.svh ====
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// datapath width for PCs and instructions
`define XLEN 32

// global branch history length
`define HIST_LEN 16

// bimodal base table, indexed by pc[9:1]
`define BIM_ENTRIES 512
`define BIM_IDX_W 9

// tagged tables T0 and T1
`define TAG_ENTRIES 256
`define TAG_IDX_W 8
`define TAG_W 10
// only the upper tag bits take part in the match
`define TAG_CMP_W 6

// direct-mapped BTB, indexed by pc[9:2], tag from pc[31:18]
`define BTB_ENTRIES 256
`define BTB_IDX_W 8
`define BTB_TAG_W 14

// statistics counter width
`define STAT_W 32

`endif

// ==== src/inst_pkg.sv ====
`default_nettype none

package inst_pkg;

    // control-flow opcodes that the fetch stage cares about
    typedef enum logic [6:0] {
        OP_OTHER  = 7'b0000000,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // map the raw opcode field onto the enum, anything else is OP_OTHER
    function automatic opcode_e decode_op(input logic [6:0] raw);
        case (raw)
            7'b1100011: return OP_BRANCH;
            7'b1101111: return OP_JAL;
            default:    return OP_OTHER;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/bpu_pkg.sv ====
`default_nettype none

package bpu_pkg;

    // 2-bit saturating direction counter
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_SNT = 2'b00;
    localparam ctr_t CTR_WNT = 2'b01;
    localparam ctr_t CTR_WT  = 2'b10;
    localparam ctr_t CTR_ST  = 2'b11;

    // component that supplied the direction
    typedef enum logic [1:0] {
        PRV_BIMODAL = 2'd0,
        PRV_T0      = 2'd1,
        PRV_T1      = 2'd2
    } provider_e;

    // statistics read select
    typedef enum logic [1:0] {
        ST_TOTAL   = 2'd0,
        ST_CORRECT = 2'd1,
        ST_TAGGED  = 2'd2
    } stat_sel_e;

endpackage

`default_nettype wire

// ==== src/tage_tables.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_defs.svh"

module tage_tables (
    input  wire                      clk,
    input  wire                      rst,
    input  wire  [`XLEN-1:0]         if_pc_i,
    input  wire                      is_cond_i,
    input  wire                      ex_branch_valid_i,
    input  wire                      ex_branch_taken_i,
    input  wire                      ex_pdt_true_i,
    input  wire  [`XLEN-1:0]         ex_pc_i,
    input  wire  [`HIST_LEN-1:0]     ex_history_i,
    output logic                     pdt_dir_o,
    output logic [`HIST_LEN-1:0]     history_o,
    output bpu_pkg::provider_e       upd_provider_o
);
    import bpu_pkg::*;

    // hash helpers, shared by the fetch and update sides
    function automatic logic [`TAG_IDX_W-1:0] t0_index(
        input logic [`XLEN-1:0] pc, input logic [`HIST_LEN-1:0] h);
        return pc[`TAG_IDX_W-1:0] ^ h[`TAG_IDX_W-1:0];
    endfunction

    function automatic logic [`TAG_IDX_W-1:0] t1_index(
        input logic [`XLEN-1:0] pc, input logic [`HIST_LEN-1:0] h);
        return pc[`TAG_IDX_W-1:0] ^ h[`HIST_LEN-1 -: `TAG_IDX_W];
    endfunction

    function automatic logic [`TAG_W-1:0] t0_tag(
        input logic [`XLEN-1:0] pc, input logic [`HIST_LEN-1:0] h);
        return pc[`TAG_IDX_W +: `TAG_W] ^ h[`HIST_LEN-1 -: `TAG_W];
    endfunction

    function automatic logic [`TAG_W-1:0] t1_tag(
        input logic [`XLEN-1:0] pc, input logic [`HIST_LEN-1:0] h);
        return pc[`TAG_IDX_W +: `TAG_W] ^
               {{(`TAG_W-`TAG_IDX_W){1'b0}}, h[`TAG_IDX_W-1:0]};
    endfunction

    // partial tag compare on the upper bits only
    function automatic logic tag_hit(
        input logic vld, input logic [`TAG_W-1:0] stored, input logic [`TAG_W-1:0] calc);
        return vld && (stored[`TAG_W-1 -: `TAG_CMP_W] == calc[`TAG_W-1 -: `TAG_CMP_W]);
    endfunction

    function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
        if (taken) begin
            return (c == CTR_ST) ? CTR_ST : ctr_t'(c + 2'd1);
        end
        return (c == CTR_SNT) ? CTR_SNT : ctr_t'(c - 2'd1);
    endfunction

    ctr_t              bim_ctr [`BIM_ENTRIES];
    ctr_t              t0_ctr  [`TAG_ENTRIES];
    ctr_t              t1_ctr  [`TAG_ENTRIES];
    logic [`TAG_W-1:0] t0_tags [`TAG_ENTRIES];
    logic [`TAG_W-1:0] t1_tags [`TAG_ENTRIES];
    logic              t0_vld  [`TAG_ENTRIES];
    logic              t1_vld  [`TAG_ENTRIES];
    logic [`HIST_LEN-1:0] ghist;

    // fetch side lookup
    logic [`TAG_IDX_W-1:0] f_t0_idx;
    logic [`TAG_IDX_W-1:0] f_t1_idx;
    logic [`BIM_IDX_W-1:0] f_bim_idx;
    logic                  f_t0_hit;
    logic                  f_t1_hit;

    assign f_t0_idx  = t0_index(if_pc_i, ghist);
    assign f_t1_idx  = t1_index(if_pc_i, ghist);
    assign f_bim_idx = if_pc_i[`BIM_IDX_W:1];
    assign f_t0_hit  = tag_hit(t0_vld[f_t0_idx], t0_tags[f_t0_idx], t0_tag(if_pc_i, ghist));
    assign f_t1_hit  = tag_hit(t1_vld[f_t1_idx], t1_tags[f_t1_idx], t1_tag(if_pc_i, ghist));

    // longest history wins
    always_comb begin
        if (f_t1_hit) begin
            pdt_dir_o = is_cond_i & t1_ctr[f_t1_idx][1];
        end else if (f_t0_hit) begin
            pdt_dir_o = is_cond_i & t0_ctr[f_t0_idx][1];
        end else begin
            pdt_dir_o = is_cond_i & bim_ctr[f_bim_idx][1];
        end
    end

    assign history_o = ghist;

    // update side, same hashes from the returned pc and history
    logic [`TAG_IDX_W-1:0] u_t0_idx;
    logic [`TAG_IDX_W-1:0] u_t1_idx;
    logic [`BIM_IDX_W-1:0] u_bim_idx;
    logic [`TAG_W-1:0]     u_t0_tag;
    logic [`TAG_W-1:0]     u_t1_tag;
    logic                  u_t0_hit;
    logic                  u_t1_hit;

    assign u_t0_idx  = t0_index(ex_pc_i, ex_history_i);
    assign u_t1_idx  = t1_index(ex_pc_i, ex_history_i);
    assign u_bim_idx = ex_pc_i[`BIM_IDX_W:1];
    assign u_t0_tag  = t0_tag(ex_pc_i, ex_history_i);
    assign u_t1_tag  = t1_tag(ex_pc_i, ex_history_i);
    assign u_t0_hit  = tag_hit(t0_vld[u_t0_idx], t0_tags[u_t0_idx], u_t0_tag);
    assign u_t1_hit  = tag_hit(t1_vld[u_t1_idx], t1_tags[u_t1_idx], u_t1_tag);

    assign upd_provider_o = u_t1_hit ? PRV_T1 : (u_t0_hit ? PRV_T0 : PRV_BIMODAL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < `BIM_ENTRIES; i++) begin
                bim_ctr[i] <= CTR_WNT;
            end
            for (int i = 0; i < `TAG_ENTRIES; i++) begin
                t0_ctr[i]  <= CTR_WNT;
                t1_ctr[i]  <= CTR_WNT;
                t0_tags[i] <= '0;
                t1_tags[i] <= '0;
                t0_vld[i]  <= 1'b0;
                t1_vld[i]  <= 1'b0;
            end
        end else if (ex_branch_valid_i) begin
            ghist <= {ghist[`HIST_LEN-2:0], ex_branch_taken_i};
            // base table always trains
            bim_ctr[u_bim_idx] <= ctr_step(bim_ctr[u_bim_idx], ex_branch_taken_i);
            case (upd_provider_o)
                PRV_T1: begin
                    if (ex_pdt_true_i) begin
                        t1_ctr[u_t1_idx] <= ctr_step(t1_ctr[u_t1_idx], ex_branch_taken_i);
                    end else begin
                        t1_ctr[u_t1_idx] <= ex_branch_taken_i ? CTR_ST : CTR_SNT;
                    end
                end
                PRV_T0: begin
                    if (ex_pdt_true_i) begin
                        t0_ctr[u_t0_idx] <= ctr_step(t0_ctr[u_t0_idx], ex_branch_taken_i);
                    end else begin
                        t0_ctr[u_t0_idx] <= ex_branch_taken_i ? CTR_ST : CTR_SNT;
                    end
                end
                default: begin
                    // bimodal mispredict, allocate a weak entry
                    if (!ex_pdt_true_i) begin
                        if (!u_t1_hit) begin
                            t1_vld[u_t1_idx]  <= 1'b1;
                            t1_tags[u_t1_idx] <= u_t1_tag;
                            t1_ctr[u_t1_idx]  <= ex_branch_taken_i ? CTR_WT : CTR_WNT;
                        end else if (!u_t0_hit) begin
                            t0_vld[u_t0_idx]  <= 1'b1;
                            t0_tags[u_t0_idx] <= u_t0_tag;
                            t0_ctr[u_t0_idx]  <= ex_branch_taken_i ? CTR_WT : CTR_WNT;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/btb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_defs.svh"

module btb (
    input  wire                 clk,
    input  wire                 rst,
    input  wire  [`XLEN-1:0]    if_pc_i,
    input  wire                 ex_branch_valid_i,
    input  wire                 ex_branch_taken_i,
    input  wire  [`XLEN-1:0]    ex_pc_i,
    input  wire  [`XLEN-1:0]    ex_target_i,
    output logic                hit_o,
    output logic [`XLEN-1:0]    target_o
);

    logic [`BTB_TAG_W-1:0] tag_mem    [`BTB_ENTRIES];
    logic [`XLEN-1:0]      target_mem [`BTB_ENTRIES];
    logic                  vld_mem    [`BTB_ENTRIES];

    logic [`BTB_IDX_W-1:0] rd_idx;
    logic [`BTB_IDX_W-1:0] wr_idx;
    logic                  fill;

    // word aligned index
    assign rd_idx = if_pc_i[`BTB_IDX_W+1:2];
    assign wr_idx = ex_pc_i[`BTB_IDX_W+1:2];
    assign fill   = ex_branch_valid_i & ex_branch_taken_i;

    assign hit_o    = vld_mem[rd_idx] &&
                      (tag_mem[rd_idx] == if_pc_i[`XLEN-1 -: `BTB_TAG_W]);
    assign target_o = target_mem[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BTB_ENTRIES; i++) begin
                vld_mem[i] <= 1'b0;
            end
        end else if (fill) begin
            vld_mem[wr_idx] <= 1'b1;
        end
    end

    // tag and target payload
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[wr_idx]    <= ex_pc_i[`XLEN-1 -: `BTB_TAG_W];
            target_mem[wr_idx] <= ex_target_i;
        end
    end

endmodule

`default_nettype wire

// ==== src/next_pc_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_defs.svh"

module next_pc_gen (
    input  wire  [`XLEN-1:0]    if_pc_i,
    input  wire  [`XLEN-1:0]    if_inst_i,
    input  wire                 pdt_dir_i,
    input  wire                 btb_hit_i,
    input  wire  [`XLEN-1:0]    btb_target_i,
    output logic                is_cond_o,
    output logic                branch_or_not_o,
    output logic                pdt_res_o,
    output logic [`XLEN-1:0]    pdt_pc_o
);
    import inst_pkg::*;

    opcode_e          opcode;
    logic             is_jal;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] j_imm;
    logic [`XLEN-1:0] imm_target;

    assign opcode = decode_op(if_inst_i[6:0]);
    assign is_jal = (opcode == OP_JAL);

    assign is_cond_o       = (opcode == OP_BRANCH);
    assign branch_or_not_o = is_cond_o | is_jal;

    // B-type offset, sign extended
    assign b_imm = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};
    // J-type offset
    assign j_imm = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};

    assign imm_target = if_pc_i + (is_jal ? j_imm : b_imm);

    // jal is unconditional, direction is already gated for branches
    assign pdt_res_o = is_jal | pdt_dir_i;

    always_comb begin
        if (!pdt_res_o) begin
            pdt_pc_o = if_pc_i + `XLEN'd4;
        end else if (btb_hit_i) begin
            pdt_pc_o = btb_target_i;
        end else begin
            // btb miss, fall back to pc relative
            pdt_pc_o = imm_target;
        end
    end

endmodule

`default_nettype wire

// ==== src/bpu_stats.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_defs.svh"

module bpu_stats (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  ex_branch_valid_i,
    input  wire                  ex_pdt_true_i,
    input  bpu_pkg::provider_e   upd_provider_i,
    input  bpu_pkg::stat_sel_e   stat_sel_i,
    input  wire                  stat_clr_i,
    output logic [`STAT_W-1:0]   stat_data_o
);
    import bpu_pkg::*;

    logic [`STAT_W-1:0] total_cnt;
    logic [`STAT_W-1:0] correct_cnt;
    logic [`STAT_W-1:0] tagged_cnt;
    logic               from_tagged;

    assign from_tagged = (upd_provider_i != PRV_BIMODAL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            total_cnt   <= '0;
            correct_cnt <= '0;
            tagged_cnt  <= '0;
        end else if (stat_clr_i) begin
            // clear takes priority over a same-cycle update
            total_cnt   <= '0;
            correct_cnt <= '0;
            tagged_cnt  <= '0;
        end else if (ex_branch_valid_i) begin
            total_cnt <= total_cnt + 1'b1;
            if (ex_pdt_true_i) begin
                correct_cnt <= correct_cnt + 1'b1;
            end
            if (from_tagged) begin
                tagged_cnt <= tagged_cnt + 1'b1;
            end
        end
    end

    // read mux
    always_comb begin
        case (stat_sel_i)
            ST_TOTAL:   stat_data_o = total_cnt;
            ST_CORRECT: stat_data_o = correct_cnt;
            ST_TAGGED:  stat_data_o = tagged_cnt;
            default:    stat_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/bpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_defs.svh"

module bpu_top (
    input  wire                     clk,
    input  wire                     rst,
    // fetch
    input  wire  [`XLEN-1:0]        if_pc_i,
    input  wire  [`XLEN-1:0]        if_inst_i,
    // execute feedback
    input  wire                     ex_branch_valid_i,
    input  wire                     ex_branch_taken_i,
    input  wire                     ex_pdt_true_i,
    input  wire  [`XLEN-1:0]        ex_pc_i,
    input  wire  [`XLEN-1:0]        ex_target_i,
    input  wire  [`HIST_LEN-1:0]    ex_history_i,
    // statistics
    input  bpu_pkg::stat_sel_e      stat_sel_i,
    input  wire                     stat_clr_i,
    // prediction
    output logic                    branch_or_not_o,
    output logic                    pdt_res_o,
    output logic [`XLEN-1:0]        pdt_pc_o,
    output logic [`HIST_LEN-1:0]    history_o,
    output logic [`STAT_W-1:0]      stat_data_o
);
    import bpu_pkg::*;

    logic             is_cond;
    logic             pdt_dir;
    logic             btb_hit;
    logic [`XLEN-1:0] btb_target;
    provider_e        upd_provider;

    next_pc_gen i_next_pc_gen (
        .if_pc_i         (if_pc_i),
        .if_inst_i       (if_inst_i),
        .pdt_dir_i       (pdt_dir),
        .btb_hit_i       (btb_hit),
        .btb_target_i    (btb_target),
        .is_cond_o       (is_cond),
        .branch_or_not_o (branch_or_not_o),
        .pdt_res_o       (pdt_res_o),
        .pdt_pc_o        (pdt_pc_o)
    );

    tage_tables i_tage_tables (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc_i),
        .is_cond_i         (is_cond),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pdt_true_i     (ex_pdt_true_i),
        .ex_pc_i           (ex_pc_i),
        .ex_history_i      (ex_history_i),
        .pdt_dir_o         (pdt_dir),
        .history_o         (history_o),
        .upd_provider_o    (upd_provider)
    );

    btb i_btb (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pc_i           (ex_pc_i),
        .ex_target_i       (ex_target_i),
        .hit_o             (btb_hit),
        .target_o          (btb_target)
    );

    bpu_stats i_bpu_stats (
        .clk               (clk),
        .rst               (rst),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_pdt_true_i     (ex_pdt_true_i),
        .upd_provider_i    (upd_provider),
        .stat_sel_i        (stat_sel_i),
        .stat_clr_i        (stat_clr_i),
        .stat_data_o       (stat_data_o)
    );

endmodule

`default_nettype wire

// ==== testbench/bpu_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_defs.svh"

module bpu_checker (
    input  wire                  clk,
    input  wire                  check_pred_i,
    input  wire                  check_stat_i,
    input  wire  [`XLEN-1:0]     if_inst_i,
    input  bpu_pkg::stat_sel_e   stat_sel_i,
    input  wire                  exp_branch_i,
    input  wire                  exp_taken_i,
    input  wire  [`XLEN-1:0]     exp_pc_i,
    input  wire  [`STAT_W-1:0]   exp_stat_i,
    input  wire  [`HIST_LEN-1:0] exp_hist_i,
    input  wire                  branch_or_not_i,
    input  wire                  pdt_res_i,
    input  wire  [`XLEN-1:0]     pdt_pc_i,
    input  wire  [`STAT_W-1:0]   stat_data_i,
    input  wire  [`HIST_LEN-1:0] history_i,
    output int                   err_cnt_o
);
    import inst_pkg::*;

    int errs = 0;

    assign err_cnt_o = errs;

    // instruction kind for the error text
    function automatic string op_label(input logic [6:0] raw);
        case (raw)
            OP_BRANCH: return "branch";
            OP_JAL:    return "jal";
            default:   return "other";
        endcase
    endfunction

    task automatic flag_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
        $display("** Error at %0t ns: %s expected %h, got %h (%s fetch)",
                 $time, sig, exp, got, op_label(if_inst_i[6:0]));
        errs++;
    endtask

    // sample late in the cycle after the falling edge drive
    always @(negedge clk) begin
        #4;
        if (check_pred_i) begin
            if (branch_or_not_i !== exp_branch_i) begin
                flag_mismatch("branch_or_not_o", 32'(exp_branch_i), 32'(branch_or_not_i));
            end
            if (pdt_res_i !== exp_taken_i) begin
                flag_mismatch("pdt_res_o", 32'(exp_taken_i), 32'(pdt_res_i));
            end
            if (pdt_pc_i !== exp_pc_i) begin
                flag_mismatch("pdt_pc_o", exp_pc_i, pdt_pc_i);
            end
            if (history_i !== exp_hist_i) begin
                flag_mismatch("history_o", 32'(exp_hist_i), 32'(history_i));
            end
        end
        if (check_stat_i && stat_data_i !== exp_stat_i) begin
            flag_mismatch($sformatf("stat_data_o (sel %0d)", stat_sel_i),
                          exp_stat_i, stat_data_i);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/bpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bpu_defs.svh"

module bpu_tb;
    import bpu_pkg::*;

    localparam int    MAX_REC   = 64;
    localparam int    N_FIELDS  = 15;
    localparam string TEST_FILE = "testbench/bpu_tests.txt";

    logic clk = 1'b0;
    logic rst;

    // DUT inputs
    logic [`XLEN-1:0]     if_pc_i;
    logic [`XLEN-1:0]     if_inst_i;
    logic                 ex_branch_valid_i;
    logic                 ex_branch_taken_i;
    logic                 ex_pdt_true_i;
    logic [`XLEN-1:0]     ex_pc_i;
    logic [`XLEN-1:0]     ex_target_i;
    logic [`HIST_LEN-1:0] ex_history_i;
    stat_sel_e            stat_sel_i;
    logic                 stat_clr_i;

    // DUT outputs
    logic                 branch_or_not_o;
    logic                 pdt_res_o;
    logic [`XLEN-1:0]     pdt_pc_o;
    logic [`HIST_LEN-1:0] history_o;
    logic [`STAT_W-1:0]   stat_data_o;

    // expected values for the checker
    logic                 chk_pred;
    logic                 chk_stat;
    logic                 exp_branch;
    logic                 exp_taken;
    logic [`XLEN-1:0]     exp_pc;
    logic [`STAT_W-1:0]   exp_stat;
    logic [`HIST_LEN-1:0] exp_hist;

    logic [31:0] rec [MAX_REC][N_FIELDS];
    int          n_rec;
    int          file_errs;
    int          mism_cnt;
    logic        loaded;

    always #5 clk = ~clk;

    bpu_top i_bpu_top (
        .clk               (clk),
        .rst               (rst),
        .if_pc_i           (if_pc_i),
        .if_inst_i         (if_inst_i),
        .ex_branch_valid_i (ex_branch_valid_i),
        .ex_branch_taken_i (ex_branch_taken_i),
        .ex_pdt_true_i     (ex_pdt_true_i),
        .ex_pc_i           (ex_pc_i),
        .ex_target_i       (ex_target_i),
        .ex_history_i      (ex_history_i),
        .stat_sel_i        (stat_sel_i),
        .stat_clr_i        (stat_clr_i),
        .branch_or_not_o   (branch_or_not_o),
        .pdt_res_o         (pdt_res_o),
        .pdt_pc_o          (pdt_pc_o),
        .history_o         (history_o),
        .stat_data_o       (stat_data_o)
    );

    bpu_checker i_checker (
        .clk             (clk),
        .check_pred_i    (chk_pred),
        .check_stat_i    (chk_stat),
        .if_inst_i       (if_inst_i),
        .stat_sel_i      (stat_sel_i),
        .exp_branch_i    (exp_branch),
        .exp_taken_i     (exp_taken),
        .exp_pc_i        (exp_pc),
        .exp_stat_i      (exp_stat),
        .exp_hist_i      (exp_hist),
        .branch_or_not_i (branch_or_not_o),
        .pdt_res_i       (pdt_res_o),
        .pdt_pc_i        (pdt_pc_o),
        .stat_data_i     (stat_data_o),
        .history_i       (history_o),
        .err_cnt_o       (mism_cnt)
    );

    // one record per line, lines starting with # are skipped
    task automatic load_tests();
        integer      fd;
        string       line;
        int          n;
        logic [31:0] f [N_FIELDS];
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open the test data file %s", TEST_FILE);
            file_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n <= 0) begin
                continue;
            end
            if (n < N_FIELDS) begin
                $display("record %0d in the test data file is incomplete", n_rec);
                file_errs++;
                continue;
            end
            if (n_rec == MAX_REC) begin
                $display("the test data file holds more than %0d records", MAX_REC);
                file_errs++;
                break;
            end
            for (int k = 0; k < N_FIELDS; k++) begin
                rec[n_rec][k] = f[k];
            end
            n_rec++;
        end
        $fclose(fd);
        if (n_rec == 0) begin
            $display("the test data file holds no records");
            file_errs++;
        end
    endtask

    task automatic drive_idle();
        chk_pred          = 1'b0;
        chk_stat          = 1'b0;
        if_pc_i           = '0;
        if_inst_i         = '0;
        ex_branch_valid_i = 1'b0;
        ex_branch_taken_i = 1'b0;
        ex_pdt_true_i     = 1'b0;
        ex_pc_i           = '0;
        ex_target_i       = '0;
        ex_history_i      = '0;
        stat_sel_i        = ST_TOTAL;
        stat_clr_i        = 1'b0;
        exp_branch        = 1'b0;
        exp_taken         = 1'b0;
        exp_pc            = '0;
        exp_stat          = '0;
    endtask

    // global history takes the outcome of the update strobe seen at the last edge
    task automatic shift_expected_history();
        if (ex_branch_valid_i) begin
            exp_hist = {exp_hist[`HIST_LEN-2:0], ex_branch_taken_i};
        end
    endtask

    task automatic drive_record(input int i);
        chk_pred          = rec[i][0][0];
        chk_stat          = rec[i][0][1];
        if_pc_i           = rec[i][1];
        if_inst_i         = rec[i][2];
        ex_branch_valid_i = rec[i][3][0];
        ex_branch_taken_i = rec[i][4][0];
        ex_pdt_true_i     = rec[i][5][0];
        ex_pc_i           = rec[i][6];
        ex_history_i      = rec[i][7][`HIST_LEN-1:0];
        ex_target_i       = rec[i][8];
        stat_sel_i        = stat_sel_e'(rec[i][9][1:0]);
        stat_clr_i        = rec[i][10][0];
        exp_branch        = rec[i][11][0];
        exp_taken         = rec[i][12][0];
        exp_pc            = rec[i][13];
        exp_stat          = rec[i][14];
    endtask

    initial begin
        loaded    = 1'b0;
        n_rec     = 0;
        file_errs = 0;
        exp_hist  = '0;
        rst       = 1'b1;
        drive_idle();
        load_tests();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_rec; i++) begin
            @(negedge clk);
            shift_expected_history();
            drive_record(i);
        end
        @(negedge clk);
        drive_idle();
        @(posedge clk);
        $display("errors: %0d value mismatches, %0d test file problems",
                 mism_cnt, file_errs);
        if (mism_cnt == 0 && file_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the number of records
    initial begin
        wait (loaded);
        #(n_rec * 10 + 200);
        $display("timeout: the run did not finish within %0d ns", n_rec * 10 + 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/bpu_tests.txt ====
# op pc inst vld tkn ok ex_pc ex_hist ex_tgt sel clr bon res exp_pc exp_stat
# op bit 0 checks the prediction, bit 1 checks stat_data_o
3 00000100 00000013 0 0 0 00000000 0000 00000000 0 0 0 0 00000104 00000000
3 00000200 00000863 0 0 0 00000000 0000 00000000 0 0 1 0 00000204 00000000
3 00000300 0200006f 0 0 0 00000000 0000 00000000 0 0 1 1 00000320 00000000
3 00000100 00000013 1 1 1 00000300 0000 00001000 0 0 0 0 00000104 00000000
3 00000300 0200006f 0 0 0 00000000 0000 00000000 0 0 1 1 00001000 00000001
3 00000100 00000013 1 1 0 00000200 5500 00000210 0 0 0 0 00000104 00000001
3 00000200 00000863 0 0 0 00000000 0000 00000000 0 0 1 1 00000210 00000002
3 00000100 00000013 1 1 1 00000200 6600 00000210 0 0 0 0 00000104 00000002
3 00000200 00000863 0 0 0 00000000 0000 00000000 0 0 1 1 00000210 00000003
3 00000100 00000013 1 0 0 00000200 7700 00000204 0 0 0 0 00000104 00000003
3 00000200 00000863 0 0 0 00000000 0000 00000000 0 0 1 1 00000210 00000004
3 00000100 00000013 1 0 1 00000400 8800 00000404 0 0 0 0 00000104 00000004
3 00000100 00000013 1 1 0 00000400 0039 00000440 0 0 0 0 00000104 00000005
3 00000400 00000863 0 0 0 00000000 0000 00000000 0 0 1 1 00000440 00000006
3 00000100 00000013 1 1 1 00000400 0039 00000440 0 0 0 0 00000104 00000006
3 00000100 00000013 0 0 0 00000000 0000 00000000 0 0 0 0 00000104 00000007
3 00000100 00000013 0 0 0 00000000 0000 00000000 1 0 0 0 00000104 00000004
3 00000100 00000013 0 0 0 00000000 0000 00000000 2 0 0 0 00000104 00000001
3 00000100 00000013 0 0 0 00000000 0000 00000000 3 0 0 0 00000104 00000000
3 00000100 00000013 0 0 0 00000000 0000 00000000 0 1 0 0 00000104 00000007
3 00000100 00000013 0 0 0 00000000 0000 00000000 0 0 0 0 00000104 00000000
3 00000100 00000013 0 0 0 00000000 0000 00000000 1 0 0 0 00000104 00000000
3 00000100 00000013 0 0 0 00000000 0000 00000000 2 0 0 0 00000104 00000000
3 00000100 00000013 1 0 1 00000100 0000 00000104 0 1 0 0 00000104 00000000
3 00000100 00000013 0 0 0 00000000 0000 00000000 0 0 0 0 00000104 00000000
3 00000100 00000013 0 0 0 00000000 0000 00000000 1 0 0 0 00000104 00000000

// ==== bpu_top.f ====
+incdir+src
src/inst_pkg.sv
src/bpu_pkg.sv
src/tage_tables.sv
src/btb.sv
src/next_pc_gen.sv
src/bpu_stats.sv
src/bpu_top.sv
testbench/bpu_checker.sv
testbench/bpu_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vbpu_tb

.PHONY: all run clean

all: $(SIM)

$(SIM): bpu_top.f src/bpu_defs.svh $(shell grep -v '^+' bpu_top.f)
	verilator --binary --timing -f bpu_top.f --top-module bpu_tb -o Vbpu_tb

run: $(SIM)
	$(SIM) | tee sim.log
	@! grep -q "TEST FAILED" sim.log
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
